/* dv/approx_mult_model.sv */
package approx_mult_model;

    ////////////////////////////////////////////////////////////////////////////
    // partial product array
    ////////////////////////////////////////////////////////////////////////////

    // bit c of row r, rows numbered 1 to 16 as in the baugh-wooley array.
    function automatic logic pp_bit(approx_mult_pkg::operand_t op, int r, int c);
        logic xb;
        logic plain;
        xb = op.x[r-1];
        plain = op.y[c] & xb;
        if (r == 16) begin
            return (c == 15) ? plain : ~plain;
        end
        return (c == 15) ? ~plain : plain;
    endfunction

    function automatic logic [31:0] column_weight(logic b, int col);
        return 32'(b) << col;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // expected product
    ////////////////////////////////////////////////////////////////////////////

    function automatic approx_mult_pkg::product_t model_product(
        approx_mult_pkg::operand_t op
    );
        logic [31:0] acc;
        acc = 32'h8000_0000;
        for (int r = 7; r <= 16; r++) begin
            for (int c = 0; c <= 15; c++) begin
                acc = acc + column_weight(pp_bit(op, r, c), r - 1 + c);
            end
        end
        // rows 1 and 2.
        acc = acc + column_weight(pp_bit(op, 1, 1) ^ pp_bit(op, 2, 0), 1);
        acc = acc + column_weight(pp_bit(op, 1, 5) & pp_bit(op, 2, 4), 6);
        acc = acc + column_weight(pp_bit(op, 1, 6) & pp_bit(op, 2, 5), 7);
        acc = acc + column_weight(pp_bit(op, 1, 10) & pp_bit(op, 2, 9), 11);
        acc = acc + column_weight(pp_bit(op, 1, 13) & pp_bit(op, 2, 12), 14);
        acc = acc + column_weight(pp_bit(op, 1, 14) ^ pp_bit(op, 2, 13), 14);
        // rows 3 and 4.
        acc = acc + column_weight(pp_bit(op, 3, 7) & pp_bit(op, 4, 6), 10);
        acc = acc + column_weight(pp_bit(op, 3, 9) & pp_bit(op, 4, 8), 12);
        acc = acc + column_weight(pp_bit(op, 3, 14) | pp_bit(op, 4, 13), 17);
        acc = acc + column_weight(pp_bit(op, 4, 15), 18);
        acc = acc + column_weight(pp_bit(op, 3, 15) | pp_bit(op, 4, 14), 17);
        acc = acc + column_weight(pp_bit(op, 3, 15) ^ pp_bit(op, 4, 14), 17);
        // rows 5 and 6.
        acc = acc + column_weight(pp_bit(op, 5, 3) & pp_bit(op, 6, 2), 8);
        acc = acc + column_weight(pp_bit(op, 5, 8) & pp_bit(op, 6, 7), 13);
        acc = acc + column_weight(pp_bit(op, 5, 10) | pp_bit(op, 6, 9), 15);
        acc = acc + column_weight(pp_bit(op, 5, 14) & pp_bit(op, 6, 13), 19);
        acc = acc + column_weight(pp_bit(op, 5, 15) & pp_bit(op, 6, 14), 20);
        acc = acc + column_weight(pp_bit(op, 5, 2) ^ pp_bit(op, 6, 1), 6);
        acc = acc + column_weight(pp_bit(op, 5, 2) & pp_bit(op, 6, 1), 7);
        acc = acc + column_weight(pp_bit(op, 5, 6) ^ pp_bit(op, 6, 5), 10);
        acc = acc + column_weight(pp_bit(op, 5, 14) & pp_bit(op, 6, 13), 18);
        acc = acc + column_weight(pp_bit(op, 5, 15) ^ pp_bit(op, 6, 14), 19);
        acc = acc + column_weight(pp_bit(op, 6, 15), 20);
        acc = acc + column_weight(pp_bit(op, 5, 9) & pp_bit(op, 6, 8), 14);
        acc = acc + column_weight(pp_bit(op, 5, 14) ^ pp_bit(op, 6, 13), 18);
        acc = acc + column_weight(pp_bit(op, 5, 10) ^ pp_bit(op, 6, 9), 14);
        acc = acc + column_weight(pp_bit(op, 5, 12) | pp_bit(op, 6, 11), 17);
        acc = acc + column_weight(pp_bit(op, 5, 13) ^ pp_bit(op, 6, 12), 17);
        return approx_mult_pkg::product_t'(acc);
    endfunction

endpackage

/* dv/tb_approx_mult_top.sv */
`timescale 1ns/1ps

`include "approx_mult_config.svh"

module tb_approx_mult_top;

    localparam int depth = `APPROX_MULT_FIFO_DEPTH;

    logic                      clk;
    logic                      arst_n;
    logic                      result_ready;
    logic                      result_valid;
    approx_mult_pkg::wb_req_t  wb_req;
    approx_mult_pkg::wb_rsp_t  wb_rsp;
    approx_mult_pkg::product_t result;

    // expected products in write order.
    approx_mult_pkg::product_t expected_q[$];

    integer seed;
    integer ready_seed;
    int     sink_mode;
    int     received;

    approx_mult_top i_approx_mult_top (
        .clk          (clk),
        .arst_n       (arst_n),
        .wb_req       (wb_req),
        .wb_rsp       (wb_rsp),
        .result       (result),
        .result_valid (result_valid),
        .result_ready (result_ready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic compare_product(approx_mult_pkg::product_t actual,
                                   approx_mult_pkg::product_t expected);
        if (actual !== expected) begin
            $display("FAILED at %0t: product %0d, expected %0d", $time, actual, expected);
            $display("tests failed");
            $fatal(1, "product mismatch");
        end
    endtask

    task automatic compare_status(logic [31:0] actual, logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED at %0t: read data %0d, expected %0d", $time, actual, expected);
            $display("tests failed");
            $fatal(1, "read data mismatch");
        end
    endtask

    task automatic stop_with(string what);
        $display("%s at %0t", what, $time);
        $display("tests failed");
        $fatal(1, "run stopped");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // wishbone driver and result sink
    ////////////////////////////////////////////////////////////////////////////

    // one access, given up after limit cycles without ack.
    task automatic bus_access(input logic we, input logic [3:0] adr, input logic [31:0] dat,
                              input int limit, output logic acked, output logic [31:0] rdat);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        acked = 1'b0;
        rdat  = '0;
        for (int i = 0; i < limit && !acked; i++) begin
            @(negedge clk);
            if (wb_rsp.ack) begin
                acked = 1'b1;
                rdat  = wb_rsp.dat;
            end
        end
        wb_req <= '0;
        @(negedge clk);
    endtask

    task automatic write_operand(logic signed [15:0] x, logic signed [15:0] y);
        logic                      acked;
        logic [31:0]               rdat;
        approx_mult_pkg::operand_t op;
        op = '{x: x, y: y};
        bus_access(1'b1, `APPROX_MULT_ADDR_OPERAND, op, 200, acked, rdat);
        if (!acked) begin
            stop_with("no ack for an operand write");
        end
        expected_q.push_back(approx_mult_model::model_product(op));
    endtask

    task automatic read_check(logic [3:0] adr, logic [31:0] expected);
        logic        acked;
        logic [31:0] rdat;
        bus_access(1'b0, adr, '0, 50, acked, rdat);
        if (!acked) begin
            stop_with("no ack for a read");
        end
        compare_status(rdat, expected);
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (expected_q.size() != 0 || result_valid) begin
            @(negedge clk);
            cycles++;
            if (cycles > 5000) begin
                stop_with("timeout waiting for results to drain");
            end
        end
    endtask

    // ready is decided on the falling edge, so the transfer is known here.
    always @(negedge clk) begin
        if (sink_mode == 0) begin
            result_ready <= 1'b1;
        end else if (sink_mode == 1) begin
            result_ready <= 1'($random(ready_seed));
        end else begin
            result_ready <= 1'b0;
        end
        #1;
        if (arst_n && result_valid && result_ready) begin
            if (expected_q.size() == 0) begin
                stop_with("result delivered with none expected");
            end
            compare_product(result, expected_q.pop_front());
            received++;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic signed [15:0] corners [5];
        logic               acked;
        logic [31:0]        rdat;
        seed         = 32'hea0018bb;
        ready_seed   = 32'hea0018bb;
        sink_mode    = 0;
        received     = 0;
        result_ready = 1'b1;
        wb_req       = '0;
        arst_n       = 1'b0;
        corners      = '{16'sd0, 16'sd1, -16'sd1, -16'sd32768, 16'sd32767};
        repeat (16) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        if (result_valid) begin
            stop_with("result valid after reset");
        end
        read_check(`APPROX_MULT_ADDR_STATUS, 32'd0);

        for (int i = 0; i < 200; i++) begin
            write_operand(16'($random(seed)), 16'($random(seed)));
        end
        wait_drained();

        foreach (corners[a]) begin
            foreach (corners[b]) begin
                write_operand(corners[a], corners[b]);
            end
        end
        wait_drained();

        sink_mode = 1;
        received  = 0;
        for (int i = 0; i < 100; i++) begin
            write_operand(16'($random(seed)), 16'($random(seed)));
        end
        wait_drained();
        if (received != 100) begin
            stop_with("random ready test lost or repeated results");
        end

        // full back-pressure, two FIFOs and the stage register.
        sink_mode = 2;
        repeat (2) @(negedge clk);
        for (int i = 0; i < 2 * depth + 1; i++) begin
            write_operand(16'($random(seed)), 16'($random(seed)));
        end
        bus_access(1'b1, `APPROX_MULT_ADDR_OPERAND, 32'h0003_0005, 40, acked, rdat);
        if (acked) begin
            stop_with("write acked with every buffer full");
        end
        read_check(`APPROX_MULT_ADDR_STATUS, 32'(depth));
        // unmapped reads stay zero while the operand FIFO holds entries.
        read_check(4'd5, 32'd0);
        sink_mode = 0;
        received  = 0;
        wait_drained();
        if (received != 2 * depth + 1) begin
            stop_with("back-pressure test lost or repeated results");
        end
        read_check(`APPROX_MULT_ADDR_STATUS, 32'd0);

        // unmapped address.
        bus_access(1'b1, 4'd5, 32'h1234_5678, 50, acked, rdat);
        if (!acked) begin
            stop_with("no ack for an unmapped write");
        end
        repeat (10) @(negedge clk);
        if (result_valid) begin
            stop_with("unmapped write produced a result");
        end
        read_check(`APPROX_MULT_ADDR_STATUS, 32'd0);

        $display("all tests passed");
        $finish;
    end

endmodule

/* flist.f */
+incdir+source
source/approx_mult_pkg.sv
source/approx_mult_16.sv
source/wb_operand_port.sv
source/sync_fifo.sv
source/mult_stage.sv
source/approx_mult_top.sv
dv/approx_mult_model.sv
dv/tb_approx_mult_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the approximate multiplier testbench with Verilator.
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir &&
verilator --binary --timing --assert -j 0 \
    -f flist.f \
    --top-module tb_approx_mult_top \
    -Mdir obj_dir &&
./obj_dir/Vtb_approx_mult_top || exit 1

exit 0

/* source/approx_mult_16.sv */
`timescale 1ns/1ps

module approx_mult_16 (
    input  logic signed [15:0]        x,
    input  logic signed [15:0]        y,
    output approx_mult_pkg::product_t z
);

    // row r holds y times x[r-1], with baugh-wooley inverted sign terms.
    logic [15:0] pp [1:16];

    // exact sum of rows 7 to 16.
    logic [31:0] exact_sum;

    // sparse compressor terms that stand in for rows 1 to 6.
    logic [20:0] c1;
    logic [20:0] c2;
    logic [20:0] c3;
    logic [20:0] c4;
    logic [20:0] c5;

    ////////////////////////////////////////////////////////////////////////////
    // partial product array
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int r = 1; r <= 15; r++) begin
            pp[r] = {~(y[15] & x[r-1]), y[14:0] & {15{x[r-1]}}};
        end
        // last row is inverted except its sign corner.
        pp[16] = {y[15] & x[15], ~(y[14:0] & {15{x[15]}})};
    end

    ////////////////////////////////////////////////////////////////////////////
    // exact upper rows
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        exact_sum = '0;
        for (int r = 7; r <= 16; r++) begin
            exact_sum = exact_sum + (32'(pp[r]) << (r - 1));
        end
        // the correction one above row 16 lands in bit 31.
        exact_sum = exact_sum + 32'h8000_0000;
    end

    ////////////////////////////////////////////////////////////////////////////
    // approximated lower rows
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        c1 = '0;
        c2 = '0;
        c3 = '0;
        c4 = '0;
        c5 = '0;

        // rows 1 and 2.
        c1[1]  = pp[1][1] ^ pp[2][0];
        c1[6]  = pp[1][5] & pp[2][4];
        c1[7]  = pp[1][6] & pp[2][5];
        c1[11] = pp[1][10] & pp[2][9];
        c1[14] = pp[1][13] & pp[2][12];
        c2[14] = pp[1][14] ^ pp[2][13];

        // rows 3 and 4.
        c1[10] = pp[3][7] & pp[4][6];
        c1[12] = pp[3][9] & pp[4][8];
        c1[17] = pp[3][14] | pp[4][13];
        c1[18] = pp[4][15];
        c2[17] = pp[3][15] | pp[4][14];
        c3[17] = pp[3][15] ^ pp[4][14];

        // rows 5 and 6.
        c1[8]  = pp[5][3] & pp[6][2];
        c1[13] = pp[5][8] & pp[6][7];
        c1[15] = pp[5][10] | pp[6][9];
        c1[19] = pp[5][14] & pp[6][13];
        c1[20] = pp[5][15] & pp[6][14];
        c2[6]  = pp[5][2] ^ pp[6][1];
        c2[7]  = pp[5][2] & pp[6][1];
        c2[10] = pp[5][6] ^ pp[6][5];
        c2[18] = pp[5][14] & pp[6][13];
        c2[19] = pp[5][15] ^ pp[6][14];
        c2[20] = pp[6][15];
        c3[14] = pp[5][9] & pp[6][8];
        c3[18] = pp[5][14] ^ pp[6][13];
        c4[14] = pp[5][10] ^ pp[6][9];
        c4[17] = pp[5][12] | pp[6][11];
        c5[17] = pp[5][13] ^ pp[6][12];
    end

    assign z = approx_mult_pkg::product_t'(exact_sum + 32'(c1) + 32'(c2) + 32'(c3)
                                          + 32'(c4) + 32'(c5));

endmodule

/* source/approx_mult_config.svh */
`ifndef APPROX_MULT_CONFIG_SVH
`define APPROX_MULT_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// buffering
////////////////////////////////////////////////////////////////////////////

// entries in each of the operand and result FIFOs.
`define APPROX_MULT_FIFO_DEPTH 4

////////////////////////////////////////////////////////////////////////////
// wishbone word address map
////////////////////////////////////////////////////////////////////////////

`define APPROX_MULT_ADDR_OPERAND 4'd0
`define APPROX_MULT_ADDR_STATUS 4'd1

`endif

/* source/approx_mult_pkg.sv */
package approx_mult_pkg;

    ////////////////////////////////////////////////////////////////////////
    // datapath payloads
    ////////////////////////////////////////////////////////////////////////

    // one operand pair in one wishbone word, y in the low halfword.
    typedef struct packed {
        logic signed [15:0] x;
        logic signed [15:0] y;
    } operand_t;

    typedef logic signed [31:0] product_t;

    ////////////////////////////////////////////////////////////////////////
    // wishbone classic bus
    ////////////////////////////////////////////////////////////////////////

    // master to slave.
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  adr;
        logic [31:0] dat;
    } wb_req_t;

    // slave to master.
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

endpackage

/* source/approx_mult_top.sv */
`timescale 1ns/1ps

`include "approx_mult_config.svh"

module approx_mult_top (
    input  logic                      clk,
    input  logic                      arst_n,
    input  approx_mult_pkg::wb_req_t  wb_req,
    output approx_mult_pkg::wb_rsp_t  wb_rsp,
    output approx_mult_pkg::product_t result,
    output logic                      result_valid,
    input  logic                      result_ready
);

    localparam int fifo_depth = `APPROX_MULT_FIFO_DEPTH;
    localparam int count_w    = $clog2(fifo_depth + 1);

    // operand side.
    logic                      op_push;
    logic                      op_full;
    logic                      op_pop;
    logic                      op_empty;
    logic [count_w-1:0]        op_count;
    approx_mult_pkg::operand_t op_wdata;
    approx_mult_pkg::operand_t op_rdata;

    // result side.
    logic                      res_push;
    logic                      res_full;
    logic                      res_pop;
    logic                      res_empty;
    approx_mult_pkg::product_t res_wdata;

    assign result_valid = ~res_empty;
    assign res_pop      = result_valid & result_ready;

    wb_operand_port #(
        .count_w (count_w)
    ) i_wb_operand_port (
        .clk    (clk),
        .arst_n (arst_n),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .push   (op_push),
        .wdata  (op_wdata),
        .full   (op_full),
        .count  (op_count)
    );

    sync_fifo #(
        .payload_t (approx_mult_pkg::operand_t),
        .depth     (fifo_depth)
    ) i_operand_fifo (
        .clk    (clk),
        .arst_n (arst_n),
        .push   (op_push),
        .wdata  (op_wdata),
        .full   (op_full),
        .pop    (op_pop),
        .rdata  (op_rdata),
        .empty  (op_empty),
        .count  (op_count)
    );

    mult_stage i_mult_stage (
        .clk       (clk),
        .arst_n    (arst_n),
        .op_pop    (op_pop),
        .op_rdata  (op_rdata),
        .op_empty  (op_empty),
        .res_push  (res_push),
        .res_wdata (res_wdata),
        .res_full  (res_full)
    );

    sync_fifo #(
        .payload_t (approx_mult_pkg::product_t),
        .depth     (fifo_depth)
    ) i_result_fifo (
        .clk    (clk),
        .arst_n (arst_n),
        .push   (res_push),
        .wdata  (res_wdata),
        .full   (res_full),
        .pop    (res_pop),
        .rdata  (result),
        .empty  (res_empty),
        .count  ()
    );

endmodule

/* source/mult_stage.sv */
`timescale 1ns/1ps

module mult_stage (
    input  logic                      clk,
    input  logic                      arst_n,
    output logic                      op_pop,
    input  approx_mult_pkg::operand_t op_rdata,
    input  logic                      op_empty,
    output logic                      res_push,
    output approx_mult_pkg::product_t res_wdata,
    input  logic                      res_full
);

    approx_mult_pkg::product_t product;
    approx_mult_pkg::product_t product_q;

    logic valid_q;

    approx_mult_16 i_approx_mult_16 (
        .x (op_rdata.x),
        .y (op_rdata.y),
        .z (product)
    );

    ////////////////////////////////////////////////////////////////////////////
    // output register
    ////////////////////////////////////////////////////////////////////////////

    assign res_push = valid_q & ~res_full;

    // refill in the same cycle the held product leaves.
    assign op_pop = ~op_empty & (~valid_q | res_push);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else if (op_pop) begin
            valid_q <= 1'b1;
        end else if (res_push) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (op_pop) begin
            product_q <= product;
        end
    end

    assign res_wdata = product_q;

    // a stalled product waits unchanged for the result FIFO.
    hold_while_stalled : assert property (
        @(posedge clk) disable iff (!arst_n)
        valid_q && !res_push |=> valid_q && $stable(product_q)
    );

endmodule

/* source/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  depth     = 4
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       push,
    input  payload_t                   wdata,
    output logic                       full,
    input  logic                       pop,
    output payload_t                   rdata,
    output logic                       empty,
    output logic [$clog2(depth+1)-1:0] count
);

    localparam int ptr_w   = (depth > 1) ? $clog2(depth) : 1;
    localparam int count_w = $clog2(depth + 1);

    payload_t mem [depth];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic             do_push;
    logic             do_pop;

    // wraps at depth, which need not be a power of two.
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full    = count == count_w'(depth);
    assign empty   = count == '0;
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    // first-word fall-through.
    assign rdata = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    no_push_when_full : assert property (@(posedge clk) disable iff (!arst_n) push |-> !full);
    no_pop_when_empty : assert property (@(posedge clk) disable iff (!arst_n) pop |-> !empty);

endmodule

/* source/wb_operand_port.sv */
`timescale 1ns/1ps

`include "approx_mult_config.svh"

module wb_operand_port #(
    parameter int count_w = $clog2(`APPROX_MULT_FIFO_DEPTH + 1)
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  approx_mult_pkg::wb_req_t   wb_req,
    output approx_mult_pkg::wb_rsp_t   wb_rsp,
    output logic                       push,
    output approx_mult_pkg::operand_t  wdata,
    input  logic                       full,
    input  logic [count_w-1:0]         count
);

    logic        ack_q;
    logic        push_q;
    logic [31:0] rd_dat_q;
    logic [31:0] status_word;

    approx_mult_pkg::operand_t wdata_q;

    logic req_new;
    logic is_operand;
    logic is_status;
    logic operand_write;
    logic accept;

    ////////////////////////////////////////////////////////////////////////////
    // decode
    ////////////////////////////////////////////////////////////////////////////

    // a request already acked this cycle is not taken again.
    assign req_new       = wb_req.cyc & wb_req.stb & ~ack_q;
    assign is_operand    = wb_req.adr == `APPROX_MULT_ADDR_OPERAND;
    assign is_status     = wb_req.adr == `APPROX_MULT_ADDR_STATUS;
    assign operand_write = req_new & wb_req.we & is_operand;

    // operand writes wait here while the FIFO is full.
    assign accept = req_new & (~operand_write | ~full);

    assign status_word = 32'(count);

    ////////////////////////////////////////////////////////////////////////////
    // ack and push
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack_q  <= 1'b0;
            push_q <= 1'b0;
        end else begin
            ack_q  <= accept;
            push_q <= accept & operand_write;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            wdata_q  <= approx_mult_pkg::operand_t'(wb_req.dat);
            rd_dat_q <= (~wb_req.we & is_status) ? status_word : '0;
        end
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = rd_dat_q;
    assign push       = push_q;
    assign wdata      = wdata_q;

    // the push trails the full check by a cycle, so room must remain.
    push_has_room : assert property (
        @(posedge clk) disable iff (!arst_n) push_q |-> !full
    );

endmodule
